/* Makefile */
# Verilator flow for the opl3 channel mixer

VERILATOR ?= verilator
FILELIST  ?= list.f
TOP       ?= tb_opl3_mixer
LINT_TOP  ?= opl3_mixer
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

$(BUILD_DIR)/$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)

sim: $(BUILD_DIR)/$(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(BUILD_DIR)

/* hdl/bus_accumulator.sv */
/*
 * output bus accumulator
 * sums the channels routed to one of the four output buses
 */
`default_nettype none

module bus_accumulator (
    input  wire                                   clk,
    input  wire                                   arst_n,
    input  wire                                   acc_clear,
    input  wire                                   ch_valid,
    input  wire  opl3_mix_pkg::chan_idx_t         ch_idx,
    input  wire  opl3_mix_pkg::chan_sample_t      ch_value,
    input  wire  [opl3_mix_pkg::NUM_CHANNELS-1:0] bus_enable,
    output opl3_mix_pkg::acc_t                    bus_sum
);
    import opl3_mix_pkg::*;

    logic add_en;

    assign add_en = ch_valid && bus_enable[ch_idx];   // channel routed to this bus

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bus_sum <= '0;
        end else if (acc_clear) begin
            bus_sum <= '0;                            // new frame
        end else if (add_en) begin
            bus_sum <= bus_sum + acc_t'(ch_value);
        end
    end

endmodule

`default_nettype wire

/* hdl/channel_router.sv */
/*
 * channel router
 * latches one bank of operator samples, builds the nine channel values
 * in two or four operator connection and steps them out one per cycle
 */
`default_nettype none

module channel_router (
    input  wire                                   clk,
    input  wire                                   arst_n,
    input  wire                                   sample_start,
    input  wire  opl3_mix_pkg::op_sample_t        op_out [opl3_mix_pkg::NUM_OPERATORS],
    input  wire  [opl3_mix_pkg::NUM_CHANNELS-1:0] cnt,
    input  wire  [opl3_mix_pkg::NUM_PAIRS-1:0]    conn_sel,
    output logic                                  ch_valid,
    output opl3_mix_pkg::chan_idx_t               ch_idx,
    output opl3_mix_pkg::chan_sample_t            ch_value,
    output logic                                  acc_clear,
    output logic                                  frame_done
);
    import opl3_mix_pkg::*;

    seq_state_e              state;
    chan_idx_t               seq_cnt;       // next channel to present
    logic                    start_frame;
    op_sample_t              op_q [NUM_OPERATORS];
    logic [NUM_CHANNELS-1:0] cnt_q;
    logic [NUM_PAIRS-1:0]    conn_sel_q;
    chan_sample_t            two_op [NUM_CHANNELS];
    chan_sample_t            chan_val [NUM_CHANNELS];

    assign start_frame = (state == SEQ_IDLE) && sample_start;  // ignored mid frame

    always_ff @(posedge clk) begin
        if (start_frame) begin
            op_q       <= op_out;
            cnt_q      <= cnt;
            conn_sel_q <= conn_sel;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= SEQ_IDLE;
            seq_cnt    <= '0;
            ch_valid   <= 1'b0;
            ch_idx     <= '0;
            acc_clear  <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            acc_clear  <= start_frame;
            ch_valid   <= 1'b0;
            frame_done <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (sample_start) begin
                        state   <= SEQ_RUN;
                        seq_cnt <= '0;
                    end
                end
                SEQ_RUN: begin
                    ch_valid <= 1'b1;
                    ch_idx   <= seq_cnt;
                    seq_cnt  <= seq_cnt + 1'b1;
                    if (seq_cnt == chan_idx_t'(NUM_CHANNELS - 1)) begin
                        state      <= SEQ_IDLE;
                        frame_done <= 1'b1;     // last channel goes out now
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_two_op
        localparam int FIRST  = c + 3 * (c / 3);    // 0-2 -> c, 3-5 -> c+3, 6-8 -> c+6
        localparam int SECOND = FIRST + 3;
        assign two_op[c] = cnt_q[c] ? chan_sample_t'(op_q[FIRST]) + chan_sample_t'(op_q[SECOND])
                                    : chan_sample_t'(op_q[SECOND]);
    end

    // channels p and p+3 merge into one four operator voice
    for (genvar p = 0; p < NUM_PAIRS; p++) begin : g_pair
        chan_sample_t op_a;
        chan_sample_t op_b;
        chan_sample_t op_c;
        chan_sample_t op_d;
        chan_sample_t four_op;

        assign op_a = chan_sample_t'(op_q[p]);
        assign op_b = chan_sample_t'(op_q[p + 3]);
        assign op_c = chan_sample_t'(op_q[p + 6]);
        assign op_d = chan_sample_t'(op_q[p + 9]);

        always_comb begin
            case ({cnt_q[p], cnt_q[p + 3]})
                2'b00:   four_op = op_d;
                2'b01:   four_op = op_b + op_d;
                2'b10:   four_op = op_a + op_d;
                default: four_op = op_a + op_c + op_d;
            endcase
        end

        assign chan_val[p]     = conn_sel_q[p] ? four_op : two_op[p];
        assign chan_val[p + 3] = conn_sel_q[p] ? '0 : two_op[p + 3];   // silent partner
    end

    for (genvar c = 2 * NUM_PAIRS; c < NUM_CHANNELS; c++) begin : g_single
        assign chan_val[c] = two_op[c];
    end

    assign ch_value = chan_val[ch_idx];

    ch_idx_in_range: assert property (
        @(posedge clk) disable iff (!arst_n)
        ch_valid |-> ch_idx < chan_idx_t'(NUM_CHANNELS)
    );

endmodule

`default_nettype wire

/* hdl/mix_regs.sv */
/*
 * APB register file for the channel mixer
 * nine channel registers (cnt and bus enables) plus the pair select
 */
`default_nettype none

module mix_regs (
    input  wire                                     clk,
    input  wire                                     arst_n,
    input  wire                                     psel,
    input  wire                                     penable,
    input  wire                                     pwrite,
    input  wire  [opl3_mix_pkg::APB_ADDR_WIDTH-1:0] paddr,
    input  wire  [opl3_mix_pkg::APB_DATA_WIDTH-1:0] pwdata,
    output logic [opl3_mix_pkg::APB_DATA_WIDTH-1:0] prdata,
    output logic                                    pready,
    output logic                                    pslverr,
    output logic [opl3_mix_pkg::NUM_CHANNELS-1:0]   cnt,
    output logic [opl3_mix_pkg::NUM_PAIRS-1:0]      conn_sel,
    output logic [opl3_mix_pkg::NUM_BUSES-1:0][opl3_mix_pkg::NUM_CHANNELS-1:0] bus_enable
);
    import opl3_mix_pkg::*;

    localparam logic [APB_DATA_WIDTH-1:0] CHAN_MASK = 8'h1f;   // cnt + four enables
    localparam logic [APB_DATA_WIDTH-1:0] SEL_MASK  = 8'h07;   // one bit per pair

    logic [APB_DATA_WIDTH-1:0] regs [NUM_REGS];
    logic                      addr_ok;
    logic                      wr_en;

    assign addr_ok = paddr <= CONN_SEL_ADDR;
    assign wr_en   = psel && penable && pwrite && addr_ok;     // access phase

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            if (paddr == CONN_SEL_ADDR) begin
                regs[paddr] <= pwdata & SEL_MASK;
            end else begin
                regs[paddr] <= pwdata & CHAN_MASK;
            end
        end
    end

    // zero wait state slave
    assign pready  = 1'b1;
    assign pslverr = psel && penable && !addr_ok;
    assign prdata  = addr_ok ? regs[paddr] : '0;              // unmapped reads zero

    always_comb begin
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            cnt[c] = regs[c][0];
            for (int b = 0; b < NUM_BUSES; b++) begin
                bus_enable[b][c] = regs[c][REG_EN_LSB + b];
            end
        end
    end

    assign conn_sel = regs[CONN_SEL_ADDR][NUM_PAIRS-1:0];

    // access phase is always entered from a selected setup phase
    penable_with_psel: assert property (
        @(posedge clk) disable iff (!arst_n)
        penable |-> psel
    );

endmodule

`default_nettype wire

/* hdl/opl3_mix_pkg.sv */
/*
 * opl3 channel mixer shared definitions
 * sample widths, counts, register map and sequencer states
 */
`default_nettype none

package opl3_mix_pkg;

    localparam int OP_WIDTH     = 13;
    localparam int CHAN_WIDTH   = 15;   // room for the three operator sum
    localparam int ACC_WIDTH    = 19;   // nine channels without wrap
    localparam int SAMPLE_WIDTH = 16;

    localparam int NUM_OPERATORS = 18;
    localparam int NUM_CHANNELS  = 9;
    localparam int NUM_BUSES     = 4;   // A, B, C, D
    localparam int NUM_PAIRS     = 3;   // four operator pairs

    localparam int APB_ADDR_WIDTH = 4;
    localparam int APB_DATA_WIDTH = 8;
    localparam int NUM_REGS       = NUM_CHANNELS + 1;
    localparam int REG_EN_LSB     = 1;  // bus A enable, B..D follow

    typedef logic signed [OP_WIDTH-1:0]     op_sample_t;
    typedef logic signed [CHAN_WIDTH-1:0]   chan_sample_t;
    typedef logic signed [ACC_WIDTH-1:0]    acc_t;
    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
    typedef logic [3:0]                     chan_idx_t;

    // channel registers sit at 0..8, pair select right above
    localparam logic [APB_ADDR_WIDTH-1:0] CONN_SEL_ADDR = 4'd9;

    typedef enum logic {
        SEQ_IDLE,
        SEQ_RUN
    } seq_state_e;

endpackage

`default_nettype wire

/* hdl/opl3_mixer.sv */
/*
 * opl3 channel mixing stage, top level
 * APB settings, channel routing, four bus accumulators and the stereo mixer
 */
`default_nettype none

module opl3_mixer (
    input  wire                                     clk,
    input  wire                                     arst_n,
    input  wire                                     psel,
    input  wire                                     penable,
    input  wire                                     pwrite,
    input  wire  [opl3_mix_pkg::APB_ADDR_WIDTH-1:0] paddr,
    input  wire  [opl3_mix_pkg::APB_DATA_WIDTH-1:0] pwdata,
    output logic [opl3_mix_pkg::APB_DATA_WIDTH-1:0] prdata,
    output logic                                    pready,
    output logic                                    pslverr,
    input  wire                                     sample_start,
    input  wire  opl3_mix_pkg::op_sample_t          op_out [opl3_mix_pkg::NUM_OPERATORS],
    output logic                                    sample_valid,
    output opl3_mix_pkg::sample_t                   sample_l,
    output opl3_mix_pkg::sample_t                   sample_r
);
    import opl3_mix_pkg::*;

    logic [NUM_CHANNELS-1:0]                 cnt;
    logic [NUM_PAIRS-1:0]                    conn_sel;
    logic [NUM_BUSES-1:0][NUM_CHANNELS-1:0]  bus_enable;
    logic                                    ch_valid;
    chan_idx_t                               ch_idx;
    chan_sample_t                            ch_value;
    logic                                    acc_clear;
    logic                                    frame_done;
    acc_t                                    bus_sum [NUM_BUSES];

    mix_regs i_mix_regs (
        .clk        (clk),
        .arst_n     (arst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .cnt        (cnt),
        .conn_sel   (conn_sel),
        .bus_enable (bus_enable)
    );

    channel_router i_channel_router (
        .clk          (clk),
        .arst_n       (arst_n),
        .sample_start (sample_start),
        .op_out       (op_out),
        .cnt          (cnt),
        .conn_sel     (conn_sel),
        .ch_valid     (ch_valid),
        .ch_idx       (ch_idx),
        .ch_value     (ch_value),
        .acc_clear    (acc_clear),
        .frame_done   (frame_done)
    );

    // one accumulator per output bus A..D
    for (genvar b = 0; b < NUM_BUSES; b++) begin : g_bus
        bus_accumulator i_bus_accumulator (
            .clk        (clk),
            .arst_n     (arst_n),
            .acc_clear  (acc_clear),
            .ch_valid   (ch_valid),
            .ch_idx     (ch_idx),
            .ch_value   (ch_value),
            .bus_enable (bus_enable[b]),
            .bus_sum    (bus_sum[b])
        );
    end

    sample_mixer i_sample_mixer (
        .clk          (clk),
        .arst_n       (arst_n),
        .frame_done   (frame_done),
        .bus_sum      (bus_sum),
        .sample_valid (sample_valid),
        .sample_l     (sample_l),
        .sample_r     (sample_r)
    );

endmodule

`default_nettype wire

/* hdl/sample_mixer.sv */
/*
 * stereo sample mixer
 * clamps the bus sums, forms left = A+C and right = B+D, issues sample_valid
 */
`default_nettype none

module sample_mixer (
    input  wire                       clk,
    input  wire                       arst_n,
    input  wire                       frame_done,
    input  wire  opl3_mix_pkg::acc_t  bus_sum [opl3_mix_pkg::NUM_BUSES],
    output logic                      sample_valid,
    output opl3_mix_pkg::sample_t     sample_l,
    output opl3_mix_pkg::sample_t     sample_r
);
    import opl3_mix_pkg::*;

    localparam acc_t SAT_MAX = acc_t'(2 ** (SAMPLE_WIDTH - 1) - 1);
    localparam acc_t SAT_MIN = acc_t'(-(2 ** (SAMPLE_WIDTH - 1)));

    function automatic sample_t saturate(input acc_t value);
        if (value > SAT_MAX) begin
            return sample_t'(SAT_MAX);
        end else if (value < SAT_MIN) begin
            return sample_t'(SAT_MIN);
        end
        return sample_t'(value);
    endfunction

    logic    mix_pending;       // last channel has been added
    sample_t bus_sat [NUM_BUSES];
    acc_t    sum_l;
    acc_t    sum_r;

    always_comb begin
        for (int b = 0; b < NUM_BUSES; b++) begin
            bus_sat[b] = saturate(bus_sum[b]);
        end
    end

    assign sum_l = acc_t'(bus_sat[0]) + acc_t'(bus_sat[2]);   // A + C
    assign sum_r = acc_t'(bus_sat[1]) + acc_t'(bus_sat[3]);   // B + D

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mix_pending  <= 1'b0;
            sample_valid <= 1'b0;
            sample_l     <= '0;
            sample_r     <= '0;
        end else begin
            mix_pending  <= frame_done;
            sample_valid <= mix_pending;
            if (mix_pending) begin
                sample_l <= saturate(sum_l);
                sample_r <= saturate(sum_r);
            end
        end
    end

    single_cycle_valid: assert property (
        @(posedge clk) disable iff (!arst_n)
        sample_valid |=> !sample_valid
    );

endmodule

`default_nettype wire

/* list.f */
hdl/opl3_mix_pkg.sv
hdl/mix_regs.sv
hdl/channel_router.sv
hdl/bus_accumulator.sv
hdl/sample_mixer.sv
hdl/opl3_mixer.sv
sim/tb_opl3_mixer.sv

/* sim/tb_opl3_mixer.sv */
/*
 * testbench for the opl3 channel mixer
 * random APB settings and operator banks, checked against a reference model
 */
`default_nettype none

module tb_opl3_mixer;
    import opl3_mix_pkg::*;

    localparam int RESET_CYCLES  = 10;
    localparam int FRAME_LATENCY = 11;
    localparam int FRAME_TIMEOUT = 40;
    localparam int NUM_FRAMES    = 25;
    localparam int SEL_ADDR      = 9;

    logic       clk;
    logic       arst_n;
    logic       psel;
    logic       penable;
    logic       pwrite;
    logic [3:0] paddr;
    logic [7:0] pwdata;
    logic [7:0] prdata;
    logic       pready;
    logic       pslverr;
    logic       sample_start;
    op_sample_t op_out [NUM_OPERATORS];
    logic       sample_valid;
    sample_t    sample_l;
    sample_t    sample_r;

    int          seed;
    int          mismatches;
    int          failures;
    logic [7:0]  shadow [NUM_REGS];     // model copy of the register file
    logic [31:0] rnd;
    int          got_l;
    int          got_r;

    opl3_mixer i_opl3_mixer (
        .clk          (clk),
        .arst_n       (arst_n),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .sample_start (sample_start),
        .op_out       (op_out),
        .sample_valid (sample_valid),
        .sample_l     (sample_l),
        .sample_r     (sample_r)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input int got, input int exp);
        $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        mismatches++;
    endtask

    task automatic report_failure(input string what);
        $display("Error at %0t: %s", $time, what);
        failures++;
    endtask

    // setup phase, access phase, then back to idle
    task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [7:0] wdata,
                              output logic [7:0] rdata, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);                 // access edge has passed, bus still held
        rdata = prdata;
        err   = pslverr;
        if (pready !== 1'b1) report_failure("pready low during the access phase");
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic reg_write(input int addr, input logic [7:0] data);
        logic [7:0] rdata;
        logic       err;
        apb_access(1'b1, 4'(addr), data, rdata, err);
        if (addr <= SEL_ADDR) begin
            shadow[addr] = (addr == SEL_ADDR) ? (data & 8'h07) : (data & 8'h1f);
            if (err) report_failure("pslverr raised on a mapped write");
        end else if (!err) begin
            report_failure("no pslverr on a write above address 9");
        end
    endtask

    task automatic reg_check(input int addr);
        logic [7:0] rdata;
        logic [7:0] exp;
        logic       err;
        apb_access(1'b0, 4'(addr), 8'h00, rdata, err);
        exp = (addr <= SEL_ADDR) ? shadow[addr] : 8'h00;
        if (rdata !== exp) report_mismatch($sformatf("prdata[%0d]", addr), int'(rdata), int'(exp));
        if (err !== (addr > SEL_ADDR)) report_failure($sformatf("wrong pslverr at %0d", addr));
    endtask

    task automatic randomize_ops();
        logic [31:0] r;
        for (int i = 0; i < NUM_OPERATORS; i++) begin
            r = $random(seed);
            op_out[i] = r[OP_WIDTH-1:0];
        end
    endtask

    task automatic randomize_settings(input bit with_pairs);
        logic [31:0] r;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            r = $random(seed);
            reg_write(c, r[7:0]);
        end
        r = $random(seed);
        reg_write(SEL_ADDR, with_pairs ? r[7:0] : 8'h00);
    endtask

    function automatic int clamp16(input int v);
        if (v > 32767) return 32767;
        if (v < -32768) return -32768;
        return v;
    endfunction

    function automatic int two_op_model(input int c);
        int first;
        int second;
        if (c < 3) first = c;
        else if (c < 6) first = c + 3;
        else first = c + 6;
        second = first + 3;
        if (shadow[c][0]) return int'(op_out[first]) + int'(op_out[second]);
        return int'(op_out[second]);
    endfunction

    function automatic void expected_outputs(output int exp_l, output int exp_r);
        int ch [NUM_CHANNELS];
        int bus [NUM_BUSES];
        int a;
        int b;
        int c3;
        int d;
        for (int c = 0; c < NUM_CHANNELS; c++) ch[c] = two_op_model(c);
        for (int p = 0; p < NUM_PAIRS; p++) begin
            if (shadow[SEL_ADDR][p]) begin
                a  = int'(op_out[p]);
                b  = int'(op_out[p + 3]);
                c3 = int'(op_out[p + 6]);
                d  = int'(op_out[p + 9]);
                case ({shadow[p][0], shadow[p + 3][0]})
                    2'b00:   ch[p] = d;
                    2'b01:   ch[p] = b + d;
                    2'b10:   ch[p] = a + d;
                    default: ch[p] = a + c3 + d;
                endcase
                ch[p + 3] = 0;          // partner is silent
            end
        end
        for (int bb = 0; bb < NUM_BUSES; bb++) begin
            bus[bb] = 0;
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                if (shadow[c][1 + bb]) bus[bb] += ch[c];
            end
            bus[bb] = clamp16(bus[bb]);
        end
        exp_l = clamp16(bus[0] + bus[2]);
        exp_r = clamp16(bus[1] + bus[3]);
    endfunction

    task automatic run_frame(input bit restart_mid, output int out_l, output int out_r);
        int exp_l;
        int exp_r;
        int cycles;
        int extra;
        bit held;
        expected_outputs(exp_l, exp_r);
        @(negedge clk);
        sample_start = 1'b1;
        cycles = 0;
        while (!sample_valid && cycles < FRAME_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            sample_start = restart_mid && (cycles == 5);   // lands mid frame
            if (cycles == 1) randomize_ops();               // bank already latched
        end
        out_l = int'(sample_l);
        out_r = int'(sample_r);
        if (!sample_valid) begin
            report_failure("timeout waiting for sample_valid");
            return;
        end
        if (cycles - 1 != FRAME_LATENCY) report_mismatch("sample_valid latency", cycles - 1,
                                                         FRAME_LATENCY);
        if (out_l != exp_l) report_mismatch("sample_l", out_l, exp_l);
        if (out_r != exp_r) report_mismatch("sample_r", out_r, exp_r);
        extra = 0;
        held  = 1'b1;
        repeat (20) begin
            @(negedge clk);
            if (sample_valid) extra++;
            if (int'(sample_l) != out_l || int'(sample_r) != out_r) held = 1'b0;
        end
        if (extra != 0) report_failure("more than one sample_valid pulse for a frame");
        if (!held) report_failure("sample outputs changed after sample_valid");
    endtask

    initial begin
        seed         = 32'ha7ae;
        mismatches   = 0;
        failures     = 0;
        arst_n       = 1'b0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        sample_start = 1'b0;
        for (int i = 0; i < NUM_OPERATORS; i++) op_out[i] = '0;
        for (int r = 0; r < NUM_REGS; r++) shadow[r] = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;
        if (sample_valid !== 1'b0 || sample_l !== '0 || sample_r !== '0) begin
            report_failure("outputs not cleared by reset");
        end
        for (int a = 0; a < NUM_REGS; a++) reg_check(a);

        // register write and readback
        for (int a = 0; a < NUM_REGS; a++) begin
            rnd = $random(seed);
            reg_write(a, rnd[7:0]);
        end
        for (int a = 0; a < NUM_REGS; a++) reg_check(a);

        // unmapped addresses
        for (int a = 10; a < 16; a++) begin
            rnd = $random(seed);
            reg_write(a, rnd[7:0]);
            reg_check(a);
        end
        for (int a = 0; a < NUM_REGS; a++) reg_check(a);

        repeat (NUM_FRAMES) begin                  // two operator frames
            randomize_settings(1'b0);
            randomize_ops();
            run_frame(1'b0, got_l, got_r);
        end
        repeat (NUM_FRAMES) begin                  // with four operator pairs
            randomize_settings(1'b1);
            randomize_ops();
            run_frame(1'b0, got_l, got_r);
        end

        // saturation at both rails
        for (int c = 0; c < NUM_CHANNELS; c++) reg_write(c, 8'h1f);
        reg_write(SEL_ADDR, 8'h00);
        for (int i = 0; i < NUM_OPERATORS; i++) op_out[i] = 13'h0fff;
        run_frame(1'b0, got_l, got_r);
        if (got_l != 32767) report_mismatch("sample_l", got_l, 32767);
        if (got_r != 32767) report_mismatch("sample_r", got_r, 32767);
        for (int i = 0; i < NUM_OPERATORS; i++) op_out[i] = 13'h1000;
        run_frame(1'b0, got_l, got_r);
        if (got_l != -32768) report_mismatch("sample_l", got_l, -32768);
        if (got_r != -32768) report_mismatch("sample_r", got_r, -32768);

        // second start while the frame runs
        randomize_settings(1'b1);
        randomize_ops();
        run_frame(1'b1, got_l, got_r);

        $display("error counts: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
